/* src/mipsCfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and address width
`define WORD_W 32

// register number width, 32 architectural registers
`define REG_IDX_W 5

// primary opcodes, instr[31:26]
`define R_TYPE 6'b000000
`define J      6'b000010
`define BEQ    6'b000100
`define ADDI   6'b001000
`define ANDI   6'b001100
`define ORI    6'b001101
`define XORI   6'b001110
`define LUI    6'b001111
`define LW     6'b100011
`define SW     6'b101011

// R-type funct codes, instr[5:0]
`define F_ADD  6'b100000
`define F_SUB  6'b100010
`define F_AND  6'b100100
`define F_OR   6'b100101
`define F_XOR  6'b100110
`define F_SLT  6'b101010

`endif

/* src/mipsPkg.sv */
`include "mipsCfg.svh"

package mipsPkg;

    // one machine word, data and addresses alike
    typedef logic [`WORD_W-1:0] word_t;

    // architectural register number
    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    // operation class from the main decoder
    // funct defers the choice to the funct field
    typedef enum logic [2:0] {
        aluOpAdd   = 3'd0,
        aluOpSub   = 3'd1,
        aluOpFunct = 3'd2,
        aluOpAnd   = 3'd3,
        aluOpOr    = 3'd4,
        aluOpXor   = 3'd5,
        aluOpLui   = 3'd6
    } aluOp_t;

    // operation the ALU actually performs
    typedef enum logic [2:0] {
        aluCtrlAdd = 3'd0,
        aluCtrlSub = 3'd1,
        aluCtrlAnd = 3'd2,
        aluCtrlOr  = 3'd3,
        aluCtrlXor = 3'd4,
        aluCtrlSlt = 3'd5,
        aluCtrlLui = 3'd6
    } aluCtrl_t;

endpackage

/* src/mainDecoder.sv */
`include "mipsCfg.svh"

module mainDecoder
    import mipsPkg::*;
(
    input  logic [5:0] op,
    output logic       regWrite,
    output logic       regDst,
    output logic       aluSrc,
    output logic       zeroExt,
    output logic       branch,
    output logic       memWrite,
    output logic       memToReg,
    output logic       jump,
    output aluOp_t     aluOp
);

    // register write for R-type, loads and all immediates
    always_comb begin
        case (op)
            `R_TYPE, `LW,
            `ADDI, `ANDI, `ORI, `XORI, `LUI: regWrite = 1'b1;
            default: regWrite = 1'b0;
        endcase
    end

    // rd as destination only for R-type, rt otherwise
    always_comb begin
        case (op)
            `R_TYPE: regDst = 1'b1;
            default: regDst = 1'b0;
        endcase
    end

    // immediate as second operand
    always_comb begin
        case (op)
            `LW, `SW,
            `ADDI, `ANDI, `ORI, `XORI, `LUI: aluSrc = 1'b1;
            default: aluSrc = 1'b0;
        endcase
    end

    // logical immediates are zero-extended
    always_comb begin
        case (op)
            `ANDI, `ORI, `XORI: zeroExt = 1'b1;
            default: zeroExt = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            `BEQ: branch = 1'b1;
            default: branch = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            `SW: memWrite = 1'b1;
            default: memWrite = 1'b0;
        endcase
    end

    // load result goes back instead of ALU result
    always_comb begin
        case (op)
            `LW: memToReg = 1'b1;
            default: memToReg = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            `J: jump = 1'b1;
            default: jump = 1'b0;
        endcase
    end

    // operation class, loads/stores/addi/unknown all add
    always_comb begin
        case (op)
            `R_TYPE: aluOp = aluOpFunct;
            `BEQ:    aluOp = aluOpSub;
            `ANDI:   aluOp = aluOpAnd;
            `ORI:    aluOp = aluOpOr;
            `XORI:   aluOp = aluOpXor;
            `LUI:    aluOp = aluOpLui;
            default: aluOp = aluOpAdd;
        endcase
    end

    // a store never also writes the register file
    always_comb begin
        noStoreWithWriteback: assert final (!(memWrite && regWrite))
            else $error("mainDecoder: memWrite and regWrite both set, op=%b", op);
    end

endmodule

/* src/aluDecoder.sv */
`include "mipsCfg.svh"

module aluDecoder
    import mipsPkg::*;
(
    input  aluOp_t     aluOp,
    input  logic [5:0] funct,
    output aluCtrl_t   aluCtrl
);

    // R-type operation from funct
    aluCtrl_t functCtrl;

    // unknown funct falls back to add
    always_comb begin
        case (funct)
            `F_ADD:  functCtrl = aluCtrlAdd;
            `F_SUB:  functCtrl = aluCtrlSub;
            `F_AND:  functCtrl = aluCtrlAnd;
            `F_OR:   functCtrl = aluCtrlOr;
            `F_XOR:  functCtrl = aluCtrlXor;
            `F_SLT:  functCtrl = aluCtrlSlt;
            default: functCtrl = aluCtrlAdd;
        endcase
    end

    // fixed classes map one to one
    always_comb begin
        case (aluOp)
            aluOpAdd:   aluCtrl = aluCtrlAdd;
            aluOpSub:   aluCtrl = aluCtrlSub;
            aluOpFunct: aluCtrl = functCtrl;
            aluOpAnd:   aluCtrl = aluCtrlAnd;
            aluOpOr:    aluCtrl = aluCtrlOr;
            aluOpXor:   aluCtrl = aluCtrlXor;
            aluOpLui:   aluCtrl = aluCtrlLui;
            default:    aluCtrl = aluCtrlAdd;
        endcase
    end

endmodule

/* src/alu.sv */
`include "mipsCfg.svh"

module alu
    import mipsPkg::*;
(
    input  word_t    a,
    input  word_t    b,
    input  aluCtrl_t aluCtrl,
    output word_t    result,
    output logic     zero
);

    localparam int halfWidth = `WORD_W / 2;

    // signed compare for slt
    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluCtrl)
            aluCtrlAdd: result = a + b;
            aluCtrlSub: result = a - b;
            aluCtrlAnd: result = a & b;
            aluCtrlOr:  result = a | b;
            aluCtrlXor: result = a ^ b;
            // set to one, upper bits cleared
            aluCtrlSlt: result = {{(`WORD_W-1){1'b0}}, lessThan};
            // low half of immediate moves up, low half cleared
            aluCtrlLui: result = {b[halfWidth-1:0], {halfWidth{1'b0}}};
            default:    result = a + b;
        endcase
    end

    // equal operands under sub, used by beq
    assign zero = (result == '0);

endmodule

/* src/regFile.sv */
`include "mipsCfg.svh"

module regFile
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t readAddr1,
    input  regIdx_t readAddr2,
    output word_t   readData1,
    output word_t   readData2,
    input  logic    writeEnable,
    input  regIdx_t writeAddr,
    input  word_t   writeDataIn
);

    localparam int numRegs = 2 ** `REG_IDX_W;

    word_t regs [numRegs];

    // r0 is never written so it stays at its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeDataIn;
        end
    end

    // asynchronous reads, new value visible after the edge
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

    regZeroReadsZero: assert property (@(posedge clk) disable iff (reset)
        ((readAddr1 != '0) || (readData1 == '0)) &&
        ((readAddr2 != '0) || (readData2 == '0)))
        else $error("regFile: register 0 read back nonzero");

endmodule

/* src/datapath.sv */
`include "mipsCfg.svh"

module datapath
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    instr,
    input  word_t    readData,
    input  logic     regWrite,
    input  logic     regDst,
    input  logic     aluSrc,
    input  logic     zeroExt,
    input  logic     branch,
    input  logic     memWrite,
    input  logic     memToReg,
    input  logic     jump,
    input  aluCtrl_t aluCtrl,
    output word_t    pc,
    output word_t    dataAddr,
    output word_t    writeData,
    output logic     zero
);

    localparam int halfWidth = `WORD_W / 2;

    // instruction fields
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    logic [halfWidth-1:0] imm;

    word_t pcPlus4;
    word_t pcBranch;
    word_t pcJump;
    word_t pcNext;
    word_t immExt;
    word_t rsVal;
    word_t rtVal;
    word_t srcB;
    word_t aluResult;
    word_t result;
    regIdx_t writeReg;

    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = instr[halfWidth-1:0];

    // pc, zero through reset and the first cycle after
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // sign extend by default, zero extend for logical immediates
    assign immExt = zeroExt ? {{halfWidth{1'b0}}, imm} : {{halfWidth{imm[halfWidth-1]}}, imm};

    // next pc candidates
    assign pcPlus4  = pc + `WORD_W'd4;
    assign pcBranch = pcPlus4 + {immExt[`WORD_W-3:0], 2'b00};
    assign pcJump   = {pcPlus4[`WORD_W-1 -: 4], instr[25:0], 2'b00};

    // jump wins over a taken branch
    always_comb begin
        if (jump) begin
            pcNext = pcJump;
        end else if (branch && zero) begin
            pcNext = pcBranch;
        end else begin
            pcNext = pcPlus4;
        end
    end

    // rd for R-type, rt for immediates and loads
    assign writeReg = regDst ? rd : rt;

    // write-back select
    assign result = memToReg ? readData : aluResult;

    regFile regFile_i (
        .clk         (clk),
        .reset       (reset),
        .readAddr1   (rs),
        .readAddr2   (rt),
        .readData1   (rsVal),
        .readData2   (rtVal),
        .writeEnable (regWrite),
        .writeAddr   (writeReg),
        .writeDataIn (result)
    );

    // second operand, register or extended immediate
    assign srcB = aluSrc ? immExt : rtVal;

    alu alu_i (
        .a       (rsVal),
        .b       (srcB),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    // effective address straight from the ALU
    assign dataAddr = aluResult;
    // store bus idles at zero outside stores
    assign writeData = memWrite ? rtVal : '0;

    pcWordAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("datapath: pc not word aligned, pc=%h", pc);

endmodule

/* src/mipsCore.sv */
module mipsCore
    import mipsPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output word_t pc,
    input  word_t instr,
    output word_t dataAddr,
    output word_t writeData,
    output logic  memWrite,
    input  word_t readData
);

    // decoder outputs
    logic     regWrite;
    logic     regDst;
    logic     aluSrc;
    logic     zeroExt;
    logic     branch;
    logic     memWriteDec;
    logic     memToReg;
    logic     jump;
    aluOp_t   aluOp;
    aluCtrl_t aluCtrl;

    mainDecoder mainDecoder_i (
        .op       (instr[31:26]),
        .regWrite (regWrite),
        .regDst   (regDst),
        .aluSrc   (aluSrc),
        .zeroExt  (zeroExt),
        .branch   (branch),
        .memWrite (memWriteDec),
        .memToReg (memToReg),
        .jump     (jump),
        .aluOp    (aluOp)
    );

    aluDecoder aluDecoder_i (
        .aluOp   (aluOp),
        .funct   (instr[5:0]),
        .aluCtrl (aluCtrl)
    );

    // no stores while reset is held
    assign memWrite = memWriteDec & ~reset;

    // zero flag only steers the branch inside the datapath
    datapath datapath_i (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .readData  (readData),
        .regWrite  (regWrite),
        .regDst    (regDst),
        .aluSrc    (aluSrc),
        .zeroExt   (zeroExt),
        .branch    (branch),
        .memWrite  (memWrite),
        .memToReg  (memToReg),
        .jump      (jump),
        .aluCtrl   (aluCtrl),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .zero      ()
    );

endmodule

/* verification/tbChecker.sv */
`include "mipsCfg.svh"

module tbChecker
    import mipsPkg::*;
#(
    parameter int imemAddrW = 10,
    parameter int dmemAddrW = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t pc,
    input  word_t dataAddr,
    input  word_t writeData,
    input  logic  memWrite,
    input  word_t imem [2**imemAddrW],
    input  word_t dmemInit [2**dmemAddrW],
    output logic  done,
    output int    errorCount
);

    timeunit 1ns;
    timeprecision 100ps;

    // kind of retired instruction, picks the test a check counts for
    localparam int kindOther = 0;
    localparam int kindLw    = 1;
    localparam int kindSw    = 2;
    localparam int kindBeq   = 3;
    localparam int kindJ     = 4;

    string testNames [1:6] = '{"reset and sequencing", "arithmetic and logic",
                               "loads and stores", "beq", "j", "register 0"};
    int    testChecks [1:6] = '{default: 0};
    int    testErrors [1:6] = '{default: 0};
    int    errors = 0;
    logic  finished = 1'b0;

    // reference machine state
    word_t   regs [32];
    word_t   mem [2**dmemAddrW];
    word_t   modelPc;
    int      prevKind;
    int      curKind;
    logic    endSeen;
    regIdx_t storeReg;
    logic    expStore;
    word_t   expAddr;
    word_t   expWData;

    assign done       = finished;
    assign errorCount = errors;

    function void setReg(input regIdx_t idx, input word_t value);
        // r0 stays zero
        if (idx != 5'd0) begin
            regs[idx] = value;
        end
    endfunction

    // one instruction of the ISA on the model state
    function void step();
        word_t   ins;
        regIdx_t rs;
        regIdx_t rt;
        word_t   a;
        word_t   b;
        word_t   simm;
        word_t   zimm;
        word_t   res;
        word_t   nextPc;
        ins    = imem[modelPc[imemAddrW+1:2]];
        rs     = ins[25:21];
        rt     = ins[20:16];
        a      = regs[rs];
        b      = regs[rt];
        simm   = {{16{ins[15]}}, ins[15:0]};
        zimm   = {16'd0, ins[15:0]};
        nextPc = modelPc + 32'd4;
        expStore = 1'b0;
        storeReg = rt;
        curKind  = kindOther;
        case (ins[31:26])
            `R_TYPE: begin
                case (ins[5:0])
                    `F_SUB:  res = a - b;
                    `F_AND:  res = a & b;
                    `F_OR:   res = a | b;
                    `F_XOR:  res = a ^ b;
                    `F_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    default: res = a + b;
                endcase
                setReg(ins[15:11], res);
            end
            `ADDI: setReg(rt, a + simm);
            `ANDI: setReg(rt, a & zimm);
            `ORI:  setReg(rt, a | zimm);
            `XORI: setReg(rt, a ^ zimm);
            `LUI:  setReg(rt, {ins[15:0], 16'd0});
            `LW: begin
                curKind = kindLw;
                res = a + simm;
                setReg(rt, mem[res[dmemAddrW+1:2]]);
            end
            `SW: begin
                curKind  = kindSw;
                expStore = 1'b1;
                expAddr  = a + simm;
                expWData = b;
                mem[expAddr[dmemAddrW+1:2]] = b;
            end
            `BEQ: begin
                curKind = kindBeq;
                if (a == b) begin
                    nextPc = nextPc + {simm[29:0], 2'b00};
                end
            end
            `J: begin
                curKind = kindJ;
                nextPc  = {nextPc[31:28], ins[25:0], 2'b00};
            end
            default: ;
        endcase
        modelPc = nextPc;
    endfunction

    task automatic check(input logic [2:0] test, input string name,
                         input word_t actual, input word_t expected);
        testChecks[test]++;
        if (actual !== expected) begin
            testErrors[test]++;
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report();
        int passed;
        int failed;
        passed = 0;
        failed = 0;
        for (int t = 1; t <= 6; t++) begin
            if (testChecks[t[2:0]] == 0) begin
                errors++;
                $display("test %0d %s: never exercised, no checks ran", t, testNames[t[2:0]]);
            end else if (testErrors[t[2:0]] == 0) begin
                $display("test %0d %s: ok, %0d checks", t, testNames[t[2:0]],
                         testChecks[t[2:0]]);
            end else begin
                $display("test %0d %s: %0d of %0d checks wrong", t, testNames[t[2:0]],
                         testErrors[t[2:0]], testChecks[t[2:0]]);
            end
            passed += testChecks[t[2:0]] - testErrors[t[2:0]];
            failed += testErrors[t[2:0]];
        end
        $display("checks passed %0d, failed %0d", passed, failed);
    endtask

    // mid-cycle sampling, the instruction retires at the next rising edge
    always @(negedge clk) begin
        word_t oldPc;
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i[4:0]] = '0;
            end
            for (int i = 0; i < 2**dmemAddrW; i++) begin
                mem[i[dmemAddrW-1:0]] = dmemInit[i[dmemAddrW-1:0]];
            end
            modelPc  = '0;
            prevKind = kindOther;
            endSeen  = 1'b0;
            check(3'd1, "memWrite", 32'(memWrite), '0);
        end else if (!finished) begin
            // pc shows where the previous instruction sent the core
            check((prevKind == kindBeq) ? 3'd4 : (prevKind == kindJ) ? 3'd5 : 3'd1,
                  "pc", pc, modelPc);
            if (endSeen) begin
                report();
                finished = 1'b1;
            end else begin
                oldPc = modelPc;
                step();
                check((curKind == kindSw || curKind == kindLw) ? 3'd3 : 3'd1,
                      "memWrite", 32'(memWrite), 32'(expStore));
                if (expStore) begin
                    check(3'd3, "dataAddr", dataAddr, expAddr);
                    check((storeReg == 5'd0) ? 3'd6 : (prevKind == kindLw) ? 3'd3 : 3'd2,
                          "writeData", writeData, expWData);
                end
                prevKind = curKind;
                // the final self-jump leaves the pc where it was
                endSeen = (modelPc == oldPc);
            end
        end
    end

endmodule

/* verification/tbTop.sv */
`include "mipsCfg.svh"

module tbTop
    import mipsPkg::*;
#(
    parameter int          numInstr = 200,
    parameter logic [31:0] seed     = 32'hb3a5
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemAddrW = 10;
    localparam int dmemAddrW = 8;

    logic  clk = 1'b0;
    logic  reset;
    word_t pc;
    word_t instr;
    word_t dataAddr;
    word_t writeData;
    word_t readData;
    logic  memWrite;
    logic  done;
    int    errorCount;

    word_t imem [2**imemAddrW];
    word_t dmem [2**dmemAddrW];
    // untouched copy for the reference model
    word_t dmemInit [2**dmemAddrW];

    logic [31:0] rngState = seed;
    int          genPos;
    logic [5:0]  functs [6] = '{`F_ADD, `F_SUB, `F_AND, `F_OR, `F_XOR, `F_SLT};
    logic [5:0]  immOps [5] = '{`ADDI, `ANDI, `ORI, `XORI, `LUI};

    always #10 clk = ~clk;

    function logic [31:0] nextRand();
        // xorshift32
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [4:0] pickReg(input logic [7:0] x, input logic isDest);
        logic [4:0] r;
        // working set r0..r9
        r = 5'(x % 8'd10);
        // r1 is the memory base, destinations fall back to r0
        return (isDest && r == 5'd1) ? 5'd0 : r;
    endfunction

    function automatic word_t encodeI(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeJ(input int index);
        return {`J, 26'(index)};
    endfunction

    // word offsets around the 0x100 base, spanning all of data memory
    function automatic logic [15:0] memOffset(input logic [7:0] x);
        return {6'd0, x, 2'b00} - 16'h0100;
    endfunction

    task automatic put(input word_t w);
        imem[genPos[imemAddrW-1:0]] = w;
        genPos++;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  d;
        logic [4:0]  s;
        logic [4:0]  t;
        int          k;
        // every unused word is a jump to itself
        for (int i = 0; i < 2**imemAddrW; i++) begin
            imem[i[imemAddrW-1:0]] = encodeJ(i);
        end
        for (int i = 0; i < 2**dmemAddrW; i++) begin
            dmemInit[i[dmemAddrW-1:0]] = nextRand();
            dmem[i[dmemAddrW-1:0]] <= dmemInit[i[dmemAddrW-1:0]];
        end
        genPos = 0;
        // a store sits at pc 0 for all of reset, r0 to address 0
        put(encodeI(`SW, 5'd0, 5'd0, 16'h0000));
        put(encodeI(`ADDI, 5'd0, 5'd1, 16'h0100));
        // r2..r9 from lui then addi
        for (int i = 2; i < 10; i++) begin
            r = nextRand();
            put(encodeI(`LUI, 5'd0, 5'(i), r[15:0]));
            put(encodeI(`ADDI, 5'(i), 5'(i), r[31:16]));
        end
        while (genPos < numInstr - 1) begin
            r  = nextRand();
            r2 = nextRand();
            d  = pickReg(r[7:0], 1'b1);
            s  = pickReg(r[15:8], 1'b0);
            t  = pickReg(r[23:16], 1'b0);
            // forward only, never past the final self-jump
            k = 1 + int'(r2[25:24]);
            if (genPos + 1 + k > numInstr - 1) begin
                k = numInstr - 2 - genPos;
            end
            case (r[31:28]) inside
                [4'd0:4'd4]: put({`R_TYPE, s, t, d, 5'd0, functs[r[26:24] % 3'd6]});
                [4'd5:4'd8]: put(encodeI(immOps[r[26:24] % 3'd5], s, d, r2[15:0]));
                4'd9, 4'd10: put(encodeI(`LW, 5'd1, d, memOffset(r2[7:0])));
                4'd12:       put(encodeI(`BEQ, s, t, 16'(k)));
                // equal operands, always taken
                4'd13:       put(encodeI(`BEQ, s, s, 16'(k)));
                4'd14:       put(encodeJ(genPos + 1 + k));
                default:     put(encodeI(`SW, 5'd1, t, memOffset(r2[7:0])));
            endcase
            // store the fresh result so it shows on the bus
            if (r[31:28] <= 4'd10 && genPos < numInstr - 1) begin
                put(encodeI(`SW, 5'd1, d, memOffset(r2[23:16])));
            end
        end
        put(encodeJ(numInstr - 1));
    endtask

    initial begin
        reset = 1'b1;
        buildProgram();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    end

    // combinational reads, store on the rising edge
    assign instr    = imem[pc[imemAddrW+1:2]];
    assign readData = dmem[dataAddr[dmemAddrW+1:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[dataAddr[dmemAddrW+1:2]] <= writeData;
        end
    end

    mipsCore mipsCore_i (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite),
        .readData  (readData)
    );

    tbChecker #(
        .imemAddrW (imemAddrW),
        .dmemAddrW (dmemAddrW)
    ) tbChecker_i (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .dataAddr   (dataAddr),
        .writeData  (writeData),
        .memWrite   (memWrite),
        .imem       (imem),
        .dmemInit   (dmemInit),
        .done       (done),
        .errorCount (errorCount)
    );

    initial begin
        wait (done === 1'b1);
        #1;
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // one cycle per instruction plus reset and some margin
    initial begin
        #((numInstr + 20) * 20);
        $display("timeout: the core never reached the final self-jump");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/mipsPkg.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/alu.sv
src/regFile.sv
src/datapath.sv
src/mipsCore.sv
verification/tbChecker.sv
verification/tbTop.sv

/* Makefile */
# Verilator build and run of the single-cycle MIPS core testbench

TOP       ?= tbTop
RTL_TOP   ?= mipsCore
LOG       ?= sim.log
SEED      ?= 45989
NUMINSTR  ?= 200
VERILATOR ?= verilator
OBJDIR    ?= obj_dir
FLIST     ?= project.f

VFLAGS ?= --binary --timing --assert -j 0
PARAMS  = -GnumInstr=$(NUMINSTR) -Gseed=$(SEED)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) $(PARAMS) -f $(FLIST) --Mdir $(OBJDIR)

# the log decides, the simulator exit code is not enough
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
